// ==== verilog/dqla_addr_pkg.sv ====
// Address map of the motor-controller register core
// 16-bit bus address split as space[15:12], channel[7:4], offset[3:0]
// Bits 11:8 are not decoded
// Only the main space is mapped; other spaces read as zero
// Channel 0 is the board, channels 1 to CHAN_LAST are motors

`default_nettype none

package dqla_addr_pkg;

    // --------------------
    // Address fields
    // --------------------
    typedef logic [15:0] reg_addr_t;    // Bus address
    typedef logic [3:0]  addr_space_t;  // Address bits 15:12
    typedef logic [3:0]  chan_t;        // Address bits 7:4
    typedef logic [3:0]  offset_t;      // Address bits 3:0

    localparam int SPACE_LSB = 12;
    localparam int CHAN_LSB  = 4;
    localparam int OFF_LSB   = 0;

    // Spaces
    localparam addr_space_t ADDR_MAIN = 4'h0;

    // Channel range of the main space
    localparam chan_t CHAN_BOARD = 4'd0;  // Board-level registers
    localparam chan_t CHAN_LAST  = 4'd8;  // Highest motor channel

    // --------------------
    // Register offsets
    // --------------------
    localparam offset_t OFF_STATUS       = 4'd0;   // Board status, channel 0 only
    localparam offset_t OFF_DAC_CTRL     = 4'd1;   // Commanded current
    localparam offset_t OFF_MOTOR_STATUS = 4'd12;  // Amp enable, fault, watchdog

    // Read source select, plain codes
    typedef logic [1:0] rd_src_t;

    localparam rd_src_t RD_ZERO         = 2'd0;
    localparam rd_src_t RD_BOARD        = 2'd1;
    localparam rd_src_t RD_CUR_CMD      = 2'd2;
    localparam rd_src_t RD_MOTOR_STATUS = 2'd3;

endpackage

`default_nettype wire

// ==== verilog/dqla_motor_pkg.sv ====
// Motor data widths and register bit positions
// Channel 1 lives in the lowest slot of every per-channel vector
// amp_fault is active low, as it comes from the amplifier

`default_nettype none

package dqla_motor_pkg;

    localparam int NUM_MOTORS = 8;

    typedef logic [31:0]                     reg_data_t;     // Bus data
    typedef logic [15:0]                     cur_cmd_t;      // Commanded current
    typedef cur_cmd_t [NUM_MOTORS-1:0]       cur_cmd_bus_t;  // All eight commands
    typedef logic [NUM_MOTORS-1:0]           motor_mask_t;   // Bit 0 is channel 1
    typedef logic [$clog2(NUM_MOTORS)-1:0]   motor_idx_t;    // Channel minus one
    typedef logic [3:0]                      board_id_t;     // Rotary switch

    // --------------------
    // Write data bits
    // --------------------
    localparam int AMP_EN_MASK_BIT = 29;  // Enable update valid
    localparam int AMP_EN_BIT      = 28;  // Enable value
    localparam int PWR_EN_MASK_BIT = 19;  // Power update valid
    localparam int PWR_EN_BIT      = 18;  // Power value

    // --------------------
    // Read words
    // --------------------
    localparam int STAT_BOARD_ID_LSB = 0;  // Board id in bits 3:0
    localparam int STAT_PWR_EN_BIT   = 8;
    localparam int STAT_WDOG_BIT     = 9;

    localparam int MSTAT_AMP_EN_BIT = 0;
    localparam int MSTAT_FAULT_BIT  = 1;   // Raw fault input, 0 means fault
    localparam int MSTAT_WDOG_BIT   = 2;

endpackage

`default_nettype wire

// ==== verilog/dqla_reg_decode.sv ====
// Address decode of the register bus, purely combinational
// Write strobes come out fully qualified; later stages never look at the address
// Channels 9 to 15 are ignored on write and select zero on read

`timescale 1ns/1ps
`default_nettype none

module dqla_reg_decode (
    input  wire dqla_addr_pkg::reg_addr_t reg_waddr,
    input  wire                           reg_wen,
    input  wire                           blk_wen,
    input  wire dqla_addr_pkg::reg_addr_t reg_raddr,
    output logic                          wr_cur_cmd,  // Motor current write
    output logic                          wr_board,    // Board status write
    output logic                          wr_blk,      // Current write in a block
    output dqla_addr_pkg::chan_t          wr_chan,
    output dqla_addr_pkg::rd_src_t        rd_src,
    output dqla_addr_pkg::chan_t          rd_chan
);
    import dqla_addr_pkg::*;

    addr_space_t w_space;
    chan_t       w_chan;
    offset_t     w_off;
    addr_space_t r_space;
    offset_t     r_off;
    logic        w_motor;  // Write hits channels 1 to 8
    logic        r_motor;

    // --------------------
    // Field split
    // --------------------
    assign w_space = reg_waddr[SPACE_LSB +: $bits(addr_space_t)];
    assign w_chan  = reg_waddr[CHAN_LSB +: $bits(chan_t)];
    assign w_off   = reg_waddr[OFF_LSB +: $bits(offset_t)];
    assign r_space = reg_raddr[SPACE_LSB +: $bits(addr_space_t)];
    assign rd_chan = reg_raddr[CHAN_LSB +: $bits(chan_t)];
    assign r_off   = reg_raddr[OFF_LSB +: $bits(offset_t)];

    assign w_motor = (w_chan != CHAN_BOARD) && (w_chan <= CHAN_LAST);
    assign r_motor = (rd_chan != CHAN_BOARD) && (rd_chan <= CHAN_LAST);

    // Write strobes
    assign wr_cur_cmd = reg_wen && (w_space == ADDR_MAIN) && w_motor && (w_off == OFF_DAC_CTRL);
    assign wr_board   = reg_wen && (w_space == ADDR_MAIN) && (w_chan == CHAN_BOARD) &&
                        (w_off == OFF_STATUS);
    assign wr_blk     = wr_cur_cmd && blk_wen;  // Only a current write requests the DAC
    assign wr_chan    = w_chan;

    // Read source select
    always_comb begin
        rd_src = RD_ZERO;  // Other spaces, bad channels, unused offsets
        if (r_space == ADDR_MAIN) begin
            if (rd_chan == CHAN_BOARD) begin
                if (r_off == OFF_STATUS) rd_src = RD_BOARD;
            end else if (r_motor) begin
                if (r_off == OFF_DAC_CTRL)          rd_src = RD_CUR_CMD;
                else if (r_off == OFF_MOTOR_STATUS) rd_src = RD_MOTOR_STATUS;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/motor_chan_regs.sv ====
// Motor channel and board registers
// Strobes must be qualified upstream; wr_chan is trusted to be 1 to 8 here
// Watchdog timeout clears amp enables every edge and beats a same-cycle enable write
// Board power is not touched by the watchdog
// One DAC request at a time; a new current write replaces it
// dac_load and wdog_clear are one-cycle registered pulses

`timescale 1ns/1ps
`default_nettype none

module motor_chan_regs (
    input  wire                             sysclk,
    input  wire                             arst_n,
    input  wire                             wr_cur_cmd,
    input  wire                             wr_board,
    input  wire                             wr_blk,
    input  wire dqla_addr_pkg::chan_t       wr_chan,
    input  wire dqla_motor_pkg::reg_data_t  wr_data,
    input  wire                             wdog_timeout,
    input  wire                             dac_busy,      // Serializer busy, level
    output dqla_motor_pkg::cur_cmd_bus_t    cur_cmd,
    output dqla_motor_pkg::motor_mask_t     amp_en,
    output logic                            pwr_en,
    output logic                            dac_load,
    output logic                            wdog_clear
);
    import dqla_addr_pkg::*;
    import dqla_motor_pkg::*;

    chan_t      chan_m1;     // Channel minus one
    motor_idx_t widx;        // Slot index of the written channel
    logic       amp_en_upd;  // Enable field valid in this write
    logic       amp_en_cmd;  // Host asks for an amp on
    logic       pwr_en_cmd;  // Host asks for power on
    logic       dac_req;     // Pending DAC update

    assign chan_m1 = wr_chan - chan_t'(1);
    assign widx    = motor_idx_t'(chan_m1);

    assign amp_en_upd = wr_cur_cmd && wr_data[AMP_EN_MASK_BIT];
    assign amp_en_cmd = amp_en_upd && wr_data[AMP_EN_BIT];
    assign pwr_en_cmd = wr_board && wr_data[PWR_EN_MASK_BIT] && wr_data[PWR_EN_BIT];

    // --------------------
    // Commanded currents
    // --------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd <= '0;
        end else if (wr_cur_cmd) begin
            cur_cmd[widx] <= cur_cmd_t'(wr_data);  // Low half of the word
        end
    end

    // --------------------
    // Enables
    // --------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            amp_en <= '0;
        end else if (wdog_timeout) begin
            amp_en <= '0;                          // Timeout wins over any write
        end else if (amp_en_upd) begin
            amp_en[widx] <= wr_data[AMP_EN_BIT];   // Other channels keep their bit
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_en <= 1'b0;
        end else if (wr_board && wr_data[PWR_EN_MASK_BIT]) begin
            pwr_en <= wr_data[PWR_EN_BIT];
        end
    end

    // Any enable-on command clears the external watchdog
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wdog_clear <= 1'b0;
        end else begin
            wdog_clear <= amp_en_cmd || pwr_en_cmd;
        end
    end

    // --------------------
    // DAC update request
    // --------------------
    // Held while busy; released as one load pulse the edge after busy drops.
    // A plain write (no blk_wen) cancels a pending request
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            dac_req  <= 1'b0;
            dac_load <= 1'b0;
        end else begin
            if (wr_cur_cmd) begin
                dac_req <= wr_blk;
            end else if (dac_req && !dac_busy) begin
                dac_req <= 1'b0;
            end
            dac_load <= dac_req && !dac_busy;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dqla_read_mux.sv ====
// Read data path, combinational, zero latency from the read address
// rd_chan is used only when rd_src selects a motor word, so it is 1 to 8 then
// Commanded current is zero-extended to the bus width

`timescale 1ns/1ps
`default_nettype none

module dqla_read_mux (
    input  wire dqla_addr_pkg::rd_src_t      rd_src,
    input  wire dqla_addr_pkg::chan_t        rd_chan,
    input  wire dqla_motor_pkg::cur_cmd_bus_t cur_cmd,
    input  wire dqla_motor_pkg::motor_mask_t amp_en,
    input  wire dqla_motor_pkg::motor_mask_t amp_fault,  // Active low
    input  wire                              pwr_en,
    input  wire                              wdog_timeout,
    input  wire dqla_motor_pkg::board_id_t   board_id,
    output dqla_motor_pkg::reg_data_t        reg_rdata
);
    import dqla_addr_pkg::*;
    import dqla_motor_pkg::*;

    chan_t      chan_m1;
    motor_idx_t ridx;        // Slot of the read channel
    reg_data_t  board_word;
    reg_data_t  mstat_word;
    reg_data_t  cur_word;

    assign chan_m1 = rd_chan - chan_t'(1);
    assign ridx    = motor_idx_t'(chan_m1);

    // --------------------
    // Word assembly
    // --------------------
    always_comb begin
        board_word = '0;
        board_word[STAT_BOARD_ID_LSB +: $bits(board_id_t)] = board_id;
        board_word[STAT_PWR_EN_BIT] = pwr_en;
        board_word[STAT_WDOG_BIT]   = wdog_timeout;

        mstat_word = '0;
        mstat_word[MSTAT_AMP_EN_BIT] = amp_en[ridx];
        mstat_word[MSTAT_FAULT_BIT]  = amp_fault[ridx];  // Mirrors the pin
        mstat_word[MSTAT_WDOG_BIT]   = wdog_timeout;

        cur_word = reg_data_t'(cur_cmd[ridx]);
    end

    // Source select
    always_comb begin
        case (rd_src)
            RD_BOARD:        reg_rdata = board_word;
            RD_CUR_CMD:      reg_rdata = cur_word;
            RD_MOTOR_STATUS: reg_rdata = mstat_word;
            default:         reg_rdata = '0;  // RD_ZERO
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/dqla_regs.sv ====
// Register core of the dual motor-controller board
// Decode, execute and result stages; no handshake, plain strobes and levels
// Writes land at the strobe edge, reads are combinational
// The DAC serializer is external: dac_busy in, cur_cmd and dac_load out

`timescale 1ns/1ps
`default_nettype none

module dqla_regs (
    input  wire                               sysclk,
    input  wire                               arst_n,
    // Register bus
    input  wire dqla_addr_pkg::reg_addr_t     reg_waddr,
    input  wire dqla_motor_pkg::reg_data_t    reg_wdata,
    input  wire                               reg_wen,
    input  wire                               blk_wen,
    input  wire dqla_addr_pkg::reg_addr_t     reg_raddr,
    output wire dqla_motor_pkg::reg_data_t    reg_rdata,
    // Board side
    input  wire dqla_motor_pkg::board_id_t    board_id,
    input  wire dqla_motor_pkg::motor_mask_t  amp_fault,    // 0 means fault
    input  wire                               wdog_timeout,
    input  wire                               dac_busy,
    output wire dqla_motor_pkg::cur_cmd_bus_t cur_cmd,
    output wire dqla_motor_pkg::motor_mask_t  amp_disable,
    output wire                               dac_load,     // Pulse
    output wire                               wdog_clear    // Pulse
);
    import dqla_addr_pkg::*;
    import dqla_motor_pkg::*;

    logic        wr_cur_cmd;
    logic        wr_board;
    logic        wr_blk;
    chan_t       wr_chan;
    rd_src_t     rd_src;
    chan_t       rd_chan;
    motor_mask_t amp_en;
    logic        pwr_en;

    // --------------------
    // Stages
    // --------------------
    dqla_reg_decode decode_i (
        .reg_waddr(reg_waddr), .reg_wen(reg_wen), .blk_wen(blk_wen),
        .reg_raddr(reg_raddr), .wr_cur_cmd(wr_cur_cmd), .wr_board(wr_board),
        .wr_blk(wr_blk), .wr_chan(wr_chan), .rd_src(rd_src), .rd_chan(rd_chan)
    );

    motor_chan_regs exec_i (
        .sysclk(sysclk), .arst_n(arst_n), .wr_cur_cmd(wr_cur_cmd), .wr_board(wr_board),
        .wr_blk(wr_blk), .wr_chan(wr_chan), .wr_data(reg_wdata),
        .wdog_timeout(wdog_timeout), .dac_busy(dac_busy), .cur_cmd(cur_cmd),
        .amp_en(amp_en), .pwr_en(pwr_en), .dac_load(dac_load), .wdog_clear(wdog_clear)
    );

    dqla_read_mux result_i (
        .rd_src(rd_src), .rd_chan(rd_chan), .cur_cmd(cur_cmd), .amp_en(amp_en),
        .amp_fault(amp_fault), .pwr_en(pwr_en), .wdog_timeout(wdog_timeout),
        .board_id(board_id), .reg_rdata(reg_rdata)
    );

    assign amp_disable = ~amp_en;  // Amplifier pins are disable-high

endmodule

`default_nettype wire

// ==== dv/dqla_regs_checker.sv ====
// Concurrent checks on the top-level ports of the register core
// Bound into every dqla_regs instance
// Sampled on the rising edge of sysclk; reset is asynchronous and active low

`timescale 1ns/1ps
`default_nettype none

module dqla_regs_checker (
    input wire                              sysclk,
    input wire                              arst_n,
    input wire                              reg_wen,
    input wire                              wdog_timeout,
    input wire dqla_motor_pkg::motor_mask_t amp_disable,
    input wire                              dac_load,
    input wire                              wdog_clear
);

    // --------------------
    // DAC load
    // --------------------
    // A second pulse needs a write in between
    dac_load_single: assert property (@(posedge sysclk) disable iff (!arst_n)
        (dac_load && !$past(reg_wen)) |=> !dac_load)
        else $error("dac_load high two cycles running without a new write");

    // Watchdog drops every amplifier
    wdog_disables_all: assert property (@(posedge sysclk) disable iff (!arst_n)
        wdog_timeout |=> (amp_disable == '1))
        else $error("amp_disable not all ones after a watchdog timeout cycle");

    pulses_low_in_reset: assert property (@(posedge sysclk)
        !arst_n |-> (!dac_load && !wdog_clear))
        else $error("dac_load or wdog_clear high during reset");

endmodule

bind dqla_regs dqla_regs_checker checker_i (
    .sysclk(sysclk), .arst_n(arst_n), .reg_wen(reg_wen), .wdog_timeout(wdog_timeout),
    .amp_disable(amp_disable), .dac_load(dac_load), .wdog_clear(wdog_clear)
);

`default_nettype wire

// ==== dv/dqla_regs_tb.sv ====
// Table-driven testbench of the motor-controller register core
// Expected values come from a small behavioral model that runs while the table is built
// Each row is one write cycle followed by a busy window and two drain cycles
// dac_busy stays high for a per-row number of edges after the write edge
// wdog_timeout and amp_fault are held for the whole row

`timescale 1ns/1ps
`default_nettype none

module dqla_regs_tb;
    import dqla_addr_pkg::*;
    import dqla_motor_pkg::*;

    localparam int        MAX_ROWS  = 32;
    localparam int        MAX_BUSY  = 6;
    localparam int        ROW_CYC   = MAX_BUSY + 3;              // Write, busy, drain
    localparam int        CYC_LIMIT = MAX_ROWS * ROW_CYC + 40;   // Reset plus margin
    localparam board_id_t BOARD_ID  = 4'hA;

    logic         sysclk = 1'b0;
    logic         arst_n;
    reg_addr_t    reg_waddr;
    reg_data_t    reg_wdata;
    logic         reg_wen;
    logic         blk_wen;
    reg_addr_t    reg_raddr;
    reg_data_t    reg_rdata;
    board_id_t    board_id;
    motor_mask_t  amp_fault;
    logic         wdog_timeout;
    logic         dac_busy;
    cur_cmd_bus_t cur_cmd;
    motor_mask_t  amp_disable;
    logic         dac_load;
    logic         wdog_clear;

    // --------------------
    // Stimulus and expected table
    // --------------------
    reg_addr_t    t_waddr [MAX_ROWS];
    reg_data_t    t_wdata [MAX_ROWS];
    logic         t_blk   [MAX_ROWS];
    int           t_busy  [MAX_ROWS];  // Edges of busy after the write edge
    logic         t_wdog  [MAX_ROWS];
    motor_mask_t  t_fault [MAX_ROWS];
    reg_addr_t    t_raddr [MAX_ROWS];
    reg_data_t    t_rdata [MAX_ROWS];  // Read result at row end
    logic         t_clear [MAX_ROWS];  // wdog_clear pulse expected
    logic         t_load  [MAX_ROWS];  // dac_load pulse expected
    cur_cmd_bus_t t_cur   [MAX_ROWS];
    motor_mask_t  t_en    [MAX_ROWS];
    int           n_rows;

    // Model state
    cur_cmd_bus_t m_cur;
    motor_mask_t  m_en;
    logic         m_pwr;
    logic [31:0]  lcg_state;
    int           cycles = 0;

    dqla_regs dut_i (
        .sysclk(sysclk), .arst_n(arst_n), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen), .blk_wen(blk_wen), .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .board_id(board_id), .amp_fault(amp_fault), .wdog_timeout(wdog_timeout),
        .dac_busy(dac_busy), .cur_cmd(cur_cmd), .amp_disable(amp_disable),
        .dac_load(dac_load), .wdog_clear(wdog_clear)
    );

    always #10 sysclk = ~sysclk;  // 20 ns period

    // Run limit
    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYC_LIMIT);
            $display("Done: errors found");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic reg_addr_t mk_addr(input addr_space_t sp, input chan_t ch,
                                          input offset_t off);
        return {sp, 4'h0, ch, off};  // Bits 11:8 left clear
    endfunction

    function automatic reg_data_t motor_word(input logic mask, input logic en,
                                             input cur_cmd_t cur);
        reg_data_t d;
        d = {16'h0, cur};
        d[AMP_EN_MASK_BIT] = mask;
        d[AMP_EN_BIT]      = en;
        return d;
    endfunction

    function automatic reg_data_t board_word(input logic mask, input logic pwr);
        reg_data_t d;
        d = '0;
        d[PWR_EN_MASK_BIT] = mask;
        d[PWR_EN_BIT]      = pwr;
        return d;
    endfunction

    task automatic next_cycle();
        @(posedge sysclk);
        #2;  // Drive and sample away from the edge
    endtask

    task automatic check_val(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Appends one row and steps the model through it
    task automatic add_row(input reg_addr_t wa, input reg_data_t wd, input logic blk,
                           input int busy, input logic wdog, input reg_addr_t ra);
        logic        motor_wr;
        logic        board_wr;
        logic        clear;
        int          widx;
        int          ridx;
        reg_data_t   rd;
        motor_mask_t fault;
        fault    = motor_mask_t'(next_rand());
        motor_wr = (wa[15:12] == ADDR_MAIN) && (wa[7:4] >= 4'd1) &&
                   (int'(wa[7:4]) <= NUM_MOTORS) && (wa[3:0] == OFF_DAC_CTRL);
        board_wr = (wa[15:12] == ADDR_MAIN) && (wa[7:4] == 4'd0) && (wa[3:0] == OFF_STATUS);
        widx     = int'(wa[7:4]) - 1;
        clear    = 1'b0;
        if (motor_wr) begin
            m_cur[widx] = wd[15:0];
            if (wd[AMP_EN_MASK_BIT]) begin
                m_en[widx] = wd[AMP_EN_BIT];
                clear      = wd[AMP_EN_BIT];  // Enable-on kicks the watchdog
            end
        end
        if (board_wr && wd[PWR_EN_MASK_BIT]) begin
            m_pwr = wd[PWR_EN_BIT];
            clear = wd[PWR_EN_BIT];
        end
        if (wdog) m_en = '0;  // Timeout beats the write
        // Expected read at row end
        rd   = '0;
        ridx = int'(ra[7:4]) - 1;
        if ((ra[15:12] == ADDR_MAIN) && (ra[7:4] == 4'd0) && (ra[3:0] == OFF_STATUS)) begin
            rd[3:0]             = BOARD_ID;
            rd[STAT_PWR_EN_BIT] = m_pwr;
            rd[STAT_WDOG_BIT]   = wdog;
        end else if ((ra[15:12] == ADDR_MAIN) && (ra[7:4] >= 4'd1) &&
                     (int'(ra[7:4]) <= NUM_MOTORS)) begin
            if (ra[3:0] == OFF_DAC_CTRL) begin
                rd = {16'h0, m_cur[ridx]};
            end else if (ra[3:0] == OFF_MOTOR_STATUS) begin
                rd[MSTAT_AMP_EN_BIT] = m_en[ridx];
                rd[MSTAT_FAULT_BIT]  = fault[ridx];
                rd[MSTAT_WDOG_BIT]   = wdog;
            end
        end
        t_waddr[n_rows] = wa;
        t_wdata[n_rows] = wd;
        t_blk[n_rows]   = blk;
        t_busy[n_rows]  = busy;
        t_wdog[n_rows]  = wdog;
        t_fault[n_rows] = fault;
        t_raddr[n_rows] = ra;
        t_rdata[n_rows] = rd;
        t_clear[n_rows] = clear;
        t_load[n_rows]  = motor_wr && blk;
        t_cur[n_rows]   = m_cur;
        t_en[n_rows]    = m_en;
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        n_rows    = 0;
        m_cur     = '0;
        m_en      = '0;
        m_pwr     = 1'b0;
        lcg_state = 32'd87;
        // Currents on every channel, odd channels enabled
        for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
            add_row(mk_addr(ADDR_MAIN, chan_t'(ch), OFF_DAC_CTRL),
                    motor_word(1'b1, ch[0], next_rand()), 1'b0, 0, 1'b0,
                    mk_addr(ADDR_MAIN, chan_t'(ch), OFF_DAC_CTRL));
        end
        // Enable mask
        add_row(mk_addr(ADDR_MAIN, 4'd3, OFF_DAC_CTRL), motor_word(1'b0, 1'b0, next_rand()),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd3, OFF_MOTOR_STATUS));
        add_row(mk_addr(ADDR_MAIN, 4'd2, OFF_DAC_CTRL), motor_word(1'b1, 1'b1, next_rand()),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd2, OFF_MOTOR_STATUS));
        add_row(mk_addr(ADDR_MAIN, 4'd3, OFF_DAC_CTRL), motor_word(1'b1, 1'b0, next_rand()),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd3, OFF_MOTOR_STATUS));
        // Board power and watchdog
        add_row(mk_addr(ADDR_MAIN, 4'd0, OFF_STATUS), board_word(1'b1, 1'b1),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd0, OFF_STATUS));
        add_row(mk_addr(ADDR_MAIN, 4'd0, OFF_STATUS), board_word(1'b0, 1'b0),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd0, OFF_STATUS));
        add_row(mk_addr(ADDR_MAIN, 4'd5, OFF_DAC_CTRL), motor_word(1'b1, 1'b1, next_rand()),
                1'b0, 0, 1'b1, mk_addr(ADDR_MAIN, 4'd5, OFF_MOTOR_STATUS));
        add_row(mk_addr(ADDR_MAIN, 4'd1, OFF_DAC_CTRL), motor_word(1'b0, 1'b0, next_rand()),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd1, OFF_MOTOR_STATUS));
        add_row(mk_addr(ADDR_MAIN, 4'd0, OFF_STATUS), board_word(1'b1, 1'b0),
                1'b0, 0, 1'b1, mk_addr(ADDR_MAIN, 4'd0, OFF_STATUS));
        // DAC request against busy
        add_row(mk_addr(ADDR_MAIN, 4'd4, OFF_DAC_CTRL), motor_word(1'b0, 1'b0, next_rand()),
                1'b1, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd4, OFF_DAC_CTRL));
        add_row(mk_addr(ADDR_MAIN, 4'd6, OFF_DAC_CTRL), motor_word(1'b0, 1'b0, next_rand()),
                1'b1, 3, 1'b0, mk_addr(ADDR_MAIN, 4'd6, OFF_DAC_CTRL));
        add_row(mk_addr(ADDR_MAIN, 4'd7, OFF_DAC_CTRL), motor_word(1'b0, 1'b0, next_rand()),
                1'b1, MAX_BUSY, 1'b0, mk_addr(ADDR_MAIN, 4'd7, OFF_DAC_CTRL));
        add_row(mk_addr(ADDR_MAIN, 4'd8, OFF_DAC_CTRL), motor_word(1'b0, 1'b0, next_rand()),
                1'b0, 2, 1'b0, mk_addr(ADDR_MAIN, 4'd8, OFF_DAC_CTRL));
        // Unmapped addresses change nothing and read zero
        add_row(mk_addr(ADDR_MAIN, 4'd0, OFF_DAC_CTRL), motor_word(1'b1, 1'b1, next_rand()),
                1'b1, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd0, OFF_DAC_CTRL));
        add_row(mk_addr(ADDR_MAIN, 4'd9, OFF_DAC_CTRL), motor_word(1'b1, 1'b1, next_rand()),
                1'b1, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd9, OFF_DAC_CTRL));
        add_row(mk_addr(ADDR_MAIN, 4'd15, OFF_DAC_CTRL), motor_word(1'b1, 1'b1, next_rand()),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd15, OFF_MOTOR_STATUS));
        add_row(mk_addr(4'd1, 4'd1, OFF_DAC_CTRL), motor_word(1'b1, 1'b1, next_rand()),
                1'b1, 0, 1'b0, mk_addr(4'd1, 4'd1, OFF_DAC_CTRL));
        add_row(mk_addr(ADDR_MAIN, 4'd2, 4'd5), motor_word(1'b1, 1'b0, next_rand()),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd2, 4'd5));
        add_row(mk_addr(4'd2, 4'd0, OFF_STATUS), board_word(1'b1, 1'b1),
                1'b0, 0, 1'b0, mk_addr(ADDR_MAIN, 4'd1, OFF_DAC_CTRL));
    endtask

    // One row: write edge, busy window, then state and read checks
    task automatic run_row(input int r);
        motor_mask_t exp_dis;
        reg_waddr    = t_waddr[r];
        reg_wdata    = t_wdata[r];
        reg_wen      = 1'b1;
        blk_wen      = t_blk[r];
        wdog_timeout = t_wdog[r];
        amp_fault    = t_fault[r];
        reg_raddr    = t_raddr[r];
        dac_busy     = (t_busy[r] > 0);
        next_cycle();  // Write edge
        reg_wen = 1'b0;
        blk_wen = 1'b0;
        check_val(128'(wdog_clear), 128'(t_clear[r]), "wdog_clear after write edge");
        check_val(128'(dac_load), 128'(0), "dac_load at write edge");
        for (int k = 1; k <= t_busy[r] + 2; k++) begin
            dac_busy = (k <= t_busy[r]);
            next_cycle();
            // Load follows the first edge that sees busy low
            check_val(128'(dac_load), 128'(t_load[r] && (k == t_busy[r] + 1)), "dac_load");
            check_val(128'(wdog_clear), 128'(0), "wdog_clear longer than one cycle");
        end
        exp_dis = ~t_en[r];
        check_val(128'(reg_rdata), 128'(t_rdata[r]), "reg_rdata");
        check_val(cur_cmd, t_cur[r], "cur_cmd");
        check_val(128'(amp_disable), 128'(exp_dis), "amp_disable");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        arst_n       = 1'b0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        reg_raddr    = '0;
        board_id     = BOARD_ID;
        amp_fault    = '1;  // No faults
        wdog_timeout = 1'b0;
        dac_busy     = 1'b0;
        build_table();
        repeat (4) @(posedge sysclk);
        #2;
        arst_n = 1'b1;
        next_cycle();
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/dqla_addr_pkg.sv
verilog/dqla_motor_pkg.sv
verilog/dqla_reg_decode.sv
verilog/motor_chan_regs.sv
verilog/dqla_read_mux.sv
verilog/dqla_regs.sv
dv/dqla_regs_checker.sv
dv/dqla_regs_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the register core testbench with Verilator.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dqla_regs_tb -Mdir obj_dir -f list.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vdqla_regs_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
